// ==== sim.f ====
verilog/dsi_proto_pkg.sv
verilog/dsi_video_pkg.sv
verilog/dsi_video_timer.sv
verilog/dsi_ecc_gen.sv
verilog/dsi_crc16.sv
verilog/dsi_frame_sequencer.sv
verilog/dsi_word_fifo.sv
verilog/dsi_lane_repacker.sv
verilog/dsi_tx_packets_assembler.sv
verification/tb_clock_gen.sv
verification/dsi_tx_tb.sv

// ==== verification/dsi_tx_cases.txt ====
# vtotal vsync vbp vact htotal hbp hact lanes bp lr_drop frames
#   exp_vss exp_hss exp_blank exp_pps exp_uf_min cmp_prev
8 1 2 3 200 2 8 1 0 0 2 2 14 6 6 0 0
8 1 2 3 200 2 8 1 1 0 2 2 14 6 6 0 1
8 1 2 3 200 2 8 2 0 0 2 2 14 6 6 0 0
8 1 2 3 200 2 8 2 1 0 2 2 14 6 6 0 1
8 1 2 3 200 2 8 3 0 0 2 2 14 6 6 0 0
8 1 2 3 200 2 8 3 1 0 2 2 14 6 6 0 1
8 1 2 3 200 2 8 4 0 0 2 2 14 6 6 0 0
8 1 2 3 200 2 8 4 1 0 2 2 14 6 6 0 1
10 2 2 4 120 3 12 4 0 1 1 1 9 4 4 4 0
10 2 2 4 120 3 12 2 0 0 2 2 18 8 8 0 0
10 2 2 4 120 3 12 2 1 0 2 2 18 8 8 0 1
10 2 2 4 120 3 12 1 0 1 1 1 9 4 4 4 0
10 2 2 4 120 3 12 3 1 1 1 1 9 4 4 4 0
10 2 2 4 120 3 12 3 0 0 1 1 9 4 4 0 0

// ==== verification/dsi_tx_tb.sv ====
module dsi_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NF       = 17;
  localparam int F_VTOT   = 0;
  localparam int F_VSYNC  = 1;
  localparam int F_VBP    = 2;
  localparam int F_VACT   = 3;
  localparam int F_HTOT   = 4;
  localparam int F_HBP    = 5;
  localparam int F_HACT   = 6;
  localparam int F_LANES  = 7;
  localparam int F_BP     = 8;
  localparam int F_LR     = 9;
  localparam int F_FRAMES = 10;
  localparam int F_VSS    = 11;
  localparam int F_HSS    = 12;
  localparam int F_BLANK  = 13;
  localparam int F_PPS    = 14;
  localparam int F_UF     = 15;
  localparam int F_CMP    = 16;

  logic        clk;
  logic        rst_n;
  logic        rst_req;
  logic        i_enable;
  logic [11:0] i_lines_vtotal;
  logic [11:0] i_lines_vsync;
  logic [11:0] i_lines_vbp;
  logic [11:0] i_lines_vact;
  logic [10:0] i_lines_htotal;
  logic [5:0]  i_lines_hbp;
  logic [9:0]  i_lines_hact;
  logic [2:0]  i_lanes_number;
  logic [31:0] i_pix_data;
  logic        i_pix_valid;
  logic        i_pix_line_ready;
  logic        i_phy_full;
  logic        o_pix_read;
  logic        o_pix_underflow;
  logic [31:0] o_phy_data;
  logic [3:0]  o_phy_write;

  int          cfg [16][NF];
  int          num_cases;
  int          errors;
  int          cycle_cnt;
  int          limit;
  int          uf_cnt;
  int          seed;
  logic        bp_on;
  logic        read_seen;
  logic        write_seen;
  logic        narrow_prev;
  logic [7:0]  stream [$];
  logic [7:0]  saved [$];

  tb_clock_gen clock_gen_inst (.i_rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  dsi_tx_packets_assembler dsi_tx_packets_assembler_inst (
    .clk(clk), .rst_n(rst_n), .i_enable(i_enable),
    .i_lines_vtotal(i_lines_vtotal), .i_lines_vsync(i_lines_vsync),
    .i_lines_vbp(i_lines_vbp), .i_lines_vact(i_lines_vact),
    .i_lines_htotal(i_lines_htotal), .i_lines_hbp(i_lines_hbp),
    .i_lines_hact(i_lines_hact), .i_lanes_number(i_lanes_number),
    .i_pix_data(i_pix_data), .i_pix_valid(i_pix_valid),
    .i_pix_line_ready(i_pix_line_ready), .o_pix_read(o_pix_read),
    .o_phy_data(o_phy_data), .o_phy_write(o_phy_write),
    .i_phy_full(i_phy_full), .o_pix_underflow(o_pix_underflow)
  );

  function automatic logic [7:0] calc_ecc(logic [23:0] d);
    logic [5:0] p;
    p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
    p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
    p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
    p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
    p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
    p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
    return {2'b00, p};
  endfunction

  // byte-wise ccitt, reflected
  function automatic logic [15:0] crc_byte(logic [15:0] c, logic [7:0] b);
    logic [15:0] r;
    r = c ^ {8'h00, b};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
    end
    return r;
  endfunction

  function automatic int ones(logic [3:0] w);
    return w[0] + w[1] + w[2] + w[3];
  endfunction

  task automatic report_mismatch(string sig, longint exp, longint got);
    $display("mismatch t=%0t %s expected=%0h got=%0h", $time, sig, exp, got);
    errors++;
  endtask

  task automatic report_failure(string msg);
    $display("error t=%0t %s", $time, msg);
    errors++;
  endtask

  // all input driving happens here, 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (!rst_n) i_pix_data = '0;
    else if (read_seen) i_pix_data = i_pix_data + 1;
    i_phy_full  = bp_on ? ($random(seed) & 1) : 1'b0;
    i_pix_valid = bp_on ? ($random(seed) & 1) : 1'b1;   // source stalls ride along
  endtask

  always @(negedge clk) begin
    read_seen  = o_pix_read;
    write_seen = (o_phy_write != 4'd0);
    if (write_seen) begin
      assert (o_phy_write inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else report_failure("lane strobes not contiguous from lane 0");
      assert (ones(o_phy_write) <= i_lanes_number)
        else report_mismatch("o_phy_write", i_lanes_number, ones(o_phy_write));
      assert (!i_phy_full) else report_failure("lane write while phy full");
      assert (!narrow_prev) else report_failure("narrow write followed by another write");
      for (int k = 0; k < 4; k++) begin
        if (o_phy_write[k]) stream.push_back(o_phy_data[8*k +: 8]);
      end
    end
    narrow_prev = write_seen && (ones(o_phy_write) < i_lanes_number);
    if (o_pix_underflow) uf_cnt++;
  end

  task automatic check_stream(int c);
    logic [7:0]  exp_ids [$];
    logic [7:0]  id;
    logic [7:0]  ecc;
    logic [7:0]  b;
    logic [7:0]  exp_b;
    logic [15:0] wc;
    logic [15:0] exp_wc;
    logic [15:0] crc;
    logic [15:0] got_crc;
    logic [31:0] pix_exp;
    int          pos;
    int          pkt;
    int          n_vss;
    int          n_hss;
    int          n_blk;
    int          n_pps;
    int          bad;
    pos     = 0;
    pkt     = 0;
    n_vss   = 0;
    n_hss   = 0;
    n_blk   = 0;
    n_pps   = 0;
    pix_exp = 0;
    for (int f = 0; f < cfg[c][F_FRAMES]; f++) begin
      exp_ids.push_back(8'h01);
      repeat (cfg[c][F_VSYNC] + cfg[c][F_VBP] - 1) exp_ids.push_back(8'h21);
      repeat (cfg[c][F_VACT]) begin
        exp_ids.push_back(8'h21);
        exp_ids.push_back(8'h19);
        exp_ids.push_back(8'h3E);
      end
      repeat (cfg[c][F_VTOT] - cfg[c][F_VSYNC] - cfg[c][F_VBP] - cfg[c][F_VACT])
        exp_ids.push_back(8'h21);
    end
    while (pos + 4 <= stream.size()) begin
      id  = stream[pos];
      wc  = {stream[pos+2], stream[pos+1]};
      ecc = stream[pos+3];
      pos += 4;
      assert (ecc == calc_ecc({wc, id})) else report_mismatch("ecc", calc_ecc({wc, id}), ecc);
      if (pkt < exp_ids.size()) begin
        assert (id == exp_ids[pkt]) else report_mismatch("data_id", exp_ids[pkt], id);
      end
      pkt++;
      if (id == 8'h01) n_vss++;
      if (id == 8'h21) n_hss++;
      if (id == 8'h19 || id == 8'h3E) begin
        exp_wc = (id == 8'h19) ? cfg[c][F_HBP] * 4 : cfg[c][F_HACT] * 3;
        assert (wc == exp_wc) else report_mismatch("word_count", exp_wc, wc);
        if (pos + wc + 2 > stream.size()) begin
          report_failure("long packet cut short at end of stream");
          break;
        end
        crc = 16'hFFFF;
        bad = 0;
        for (int i = 0; i < wc; i++) begin
          b     = stream[pos+i];
          crc   = crc_byte(crc, b);
          exp_b = (id == 8'h19) ? 8'h00 : 8'((pix_exp + i / 4) >> (8 * (i % 4)));
          if (b != exp_b && bad == 0) begin
            report_mismatch((id == 8'h19) ? "blank_payload" : "pixel_payload", exp_b, b);
            bad = 1;   // one line per packet
          end
        end
        if (id == 8'h3E) pix_exp += wc / 4;
        got_crc = {stream[pos+wc+1], stream[pos+wc]};
        assert (got_crc == crc) else report_mismatch("crc", crc, got_crc);
        pos += wc + 2;
        if (id == 8'h19) n_blk++;
        else n_pps++;
      end
    end
    assert (pos == stream.size()) else report_failure("stray bytes at end of stream");
    assert (pkt == exp_ids.size()) else report_mismatch("packet_count", exp_ids.size(), pkt);
    assert (n_vss == cfg[c][F_VSS]) else report_mismatch("vss_count", cfg[c][F_VSS], n_vss);
    assert (n_hss == cfg[c][F_HSS]) else report_mismatch("hss_count", cfg[c][F_HSS], n_hss);
    assert (n_blk == cfg[c][F_BLANK]) else report_mismatch("blank_count", cfg[c][F_BLANK], n_blk);
    assert (n_pps == cfg[c][F_PPS]) else report_mismatch("pps_count", cfg[c][F_PPS], n_pps);
  endtask

  task automatic run_case(int c);
    int   run_len;
    int   idle;
    logic same;
    i_enable = 1'b0;
    bp_on    = 1'b0;
    i_lines_vtotal   = cfg[c][F_VTOT];
    i_lines_vsync    = cfg[c][F_VSYNC];
    i_lines_vbp      = cfg[c][F_VBP];
    i_lines_vact     = cfg[c][F_VACT];
    i_lines_htotal   = cfg[c][F_HTOT];
    i_lines_hbp      = cfg[c][F_HBP];
    i_lines_hact     = cfg[c][F_HACT];
    i_lanes_number   = cfg[c][F_LANES];
    i_pix_line_ready = 1'b1;
    rst_req = 1'b1;
    next_cycle();
    rst_req = 1'b0;
    repeat (5) next_cycle();
    stream.delete();
    uf_cnt   = 0;
    bp_on    = cfg[c][F_BP];
    i_enable = 1'b1;
    // stop just before the line end that closes the last frame
    run_len = cfg[c][F_HTOT] * (1 + cfg[c][F_FRAMES] * cfg[c][F_VTOT]) - 1;
    for (int k = 1; k <= run_len; k++) begin
      next_cycle();
      if (cfg[c][F_LR] != 0 && k == cfg[c][F_HTOT]) i_pix_line_ready = 1'b0;
    end
    i_enable = 1'b0;
    bp_on    = 1'b0;
    idle = 0;
    while (idle < 32) begin
      next_cycle();
      idle = write_seen ? 0 : idle + 1;
    end
    check_stream(c);
    if (cfg[c][F_UF] == 0) begin
      assert (uf_cnt == 0) else report_mismatch("o_pix_underflow", 0, uf_cnt);
    end else begin
      assert (uf_cnt >= cfg[c][F_UF]) else report_failure("underflow pulsed too few times");
    end
    if (cfg[c][F_CMP] != 0) begin
      same = (stream.size() == saved.size());
      for (int i = 0; i < stream.size() && same; i++) begin
        same = (stream[i] == saved[i]);
      end
      assert (same) else report_failure("stream differs from reference case");
    end
    saved = stream;
  endtask

  initial begin
    begin : watchdog
      wait (limit != 0);
      while (cycle_cnt <= limit) begin
        @(posedge clk);
        cycle_cnt++;
      end
      $display("timeout after %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    n;
    int    start_err;
    int    passed;
    int    f [NF];
    string line;
    rst_req          = 1'b0;
    i_enable         = 1'b0;
    bp_on            = 1'b0;
    i_pix_data       = '0;
    i_pix_valid      = 1'b1;
    i_pix_line_ready = 1'b0;
    i_phy_full       = 1'b0;
    i_lanes_number   = 3'd1;
    i_lines_vtotal   = '0;
    i_lines_vsync    = '0;
    i_lines_vbp      = '0;
    i_lines_vact     = '0;
    i_lines_htotal   = '0;
    i_lines_hbp      = '0;
    i_lines_hact     = '0;
    read_seen        = 1'b0;
    write_seen       = 1'b0;
    narrow_prev      = 1'b0;
    errors           = 0;
    cycle_cnt        = 0;
    limit            = 0;
    num_cases        = 0;
    passed           = 0;
    seed             = 46;
    fd = $fopen("verification/dsi_tx_cases.txt", "r");
    if (fd == 0) begin
      $display("error cannot open case file");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && num_cases < 16) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
        if (n != NF) continue;
        for (int i = 0; i < NF; i++) cfg[num_cases][i] = f[i];
        limit += 3 * f[F_FRAMES] * f[F_VTOT] * f[F_HTOT];
        num_cases++;
      end
      $fclose(fd);
      for (int c = 0; c < num_cases; c++) begin
        start_err = errors;
        run_case(c);
        if (errors == start_err) passed++;
        $display("case %0d lanes=%0d bp=%0d line_ready_drop=%0d: %s (%0d errors)", c,
                 cfg[c][F_LANES], cfg[c][F_BP], cfg[c][F_LR],
                 (errors == start_err) ? "pass" : "fail", errors - start_err);
      end
      $display("cases run %0d, passed %0d, failed %0d, errors %0d", num_cases, passed,
               num_cases - passed, errors);
      if (errors == 0 && num_cases > 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
  input  logic i_rst_req,
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [1:0] hold = 2'd3;   // cycles of reset left

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (i_rst_req) begin
      hold <= 2'd3;
    end else if (hold != 2'd0) begin
      hold <= hold - 2'd1;
    end
  end

  assign rst_n = (hold == 2'd0);

endmodule

// ==== verilog/dsi_tx_packets_assembler.sv ====
module dsi_tx_packets_assembler (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_enable,
  input  dsi_video_pkg::vlines_t              i_lines_vtotal,
  input  dsi_video_pkg::vlines_t              i_lines_vsync,
  input  dsi_video_pkg::vlines_t              i_lines_vbp,
  input  dsi_video_pkg::vlines_t              i_lines_vact,
  input  dsi_video_pkg::hpix_t                i_lines_htotal,
  input  dsi_video_pkg::hbp_t                 i_lines_hbp,
  input  dsi_video_pkg::hact_t                i_lines_hact,
  input  dsi_proto_pkg::lane_count_t          i_lanes_number,
  input  dsi_proto_pkg::word_t                i_pix_data,
  input  logic                                i_pix_valid,
  input  logic                                i_pix_line_ready,
  output logic                                o_pix_read,
  output dsi_proto_pkg::word_t                o_phy_data,
  output logic [dsi_proto_pkg::MAX_LANES-1:0] o_phy_write,
  input  logic                                i_phy_full,
  output logic                                o_pix_underflow
);
  import dsi_proto_pkg::*;

  logic        line_start;
  logic        line_end;
  logic        last_vbp;
  logic        last_act;
  logic        last_vfp;
  logic        fifo_write;
  logic        fifo_read;
  logic        fifo_empty;
  logic        fifo_full;
  fifo_entry_t fifo_entry;
  fifo_entry_t fifo_head;

  dsi_video_timer dsi_video_timer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_enable       (i_enable),
    .i_lines_htotal (i_lines_htotal),
    .i_lines_vtotal (i_lines_vtotal),
    .i_lines_vsync  (i_lines_vsync),
    .i_lines_vbp    (i_lines_vbp),
    .i_lines_vact   (i_lines_vact),
    .o_line_start   (line_start),
    .o_line_end     (line_end),
    .o_last_vbp     (last_vbp),
    .o_last_act     (last_act),
    .o_last_vfp     (last_vfp)
  );

  dsi_frame_sequencer dsi_frame_sequencer_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_enable         (i_enable),
    .i_line_start     (line_start),
    .i_line_end       (line_end),
    .i_last_vbp       (last_vbp),
    .i_last_act       (last_act),
    .i_last_vfp       (last_vfp),
    .i_lines_hbp      (i_lines_hbp),
    .i_lines_hact     (i_lines_hact),
    .i_pix_data       (i_pix_data),
    .i_pix_valid      (i_pix_valid),
    .i_pix_line_ready (i_pix_line_ready),
    .i_fifo_full      (fifo_full),
    .o_pix_read       (o_pix_read),
    .o_fifo_write     (fifo_write),
    .o_fifo_entry     (fifo_entry),
    .o_pix_underflow  (o_pix_underflow)
  );

  dsi_word_fifo dsi_word_fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_write (fifo_write),
    .i_entry (fifo_entry),
    .i_read  (fifo_read),
    .o_head  (fifo_head),
    .o_empty (fifo_empty),
    .o_full  (fifo_full)
  );

  dsi_lane_repacker dsi_lane_repacker_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_lanes_number (i_lanes_number),
    .i_head         (fifo_head),
    .i_empty        (fifo_empty),
    .i_phy_full     (i_phy_full),
    .o_read         (fifo_read),
    .o_phy_data     (o_phy_data),
    .o_phy_write    (o_phy_write)
  );

endmodule

// ==== verilog/dsi_lane_repacker.sv ====
module dsi_lane_repacker (
  input  logic                                clk,
  input  logic                                rst_n,
  input  dsi_proto_pkg::lane_count_t          i_lanes_number,
  input  dsi_proto_pkg::fifo_entry_t          i_head,
  input  logic                                i_empty,
  input  logic                                i_phy_full,
  output logic                                o_read,
  output dsi_proto_pkg::word_t                o_phy_data,
  output logic [dsi_proto_pkg::MAX_LANES-1:0] o_phy_write
);
  import dsi_proto_pkg::*;

  logic [SHIFT_BYTES*8-1:0] shift_q;
  logic [SHIFT_BYTES*8-1:0] load_wide;
  logic [3:0]               held;
  logic [3:0]               lanes;
  logic [3:0]               out_bytes;
  logic [3:0]               in_bytes;
  logic [3:0]               free_bytes;
  logic                     out_write;
  word_t                    load_word;

  assign lanes      = {1'b0, i_lanes_number};
  // flush a short tail once the fifo has run dry
  assign out_write  = !i_phy_full & ((held >= lanes) | ((held != '0) & i_empty));
  assign out_bytes  = (held >= lanes) ? lanes : held;
  assign free_bytes = 4'(SHIFT_BYTES) - held + (out_write ? out_bytes : 4'd0);
  assign o_read     = (free_bytes >= 4'd4) & !i_empty;

  assign in_bytes  = i_head[WORD_W] ? 4'd2 : 4'd4;
  assign load_word = i_head[WORD_W] ? {16'b0, i_head[15:0]} : i_head[WORD_W-1:0];
  assign load_wide = {{(SHIFT_BYTES*8-WORD_W){1'b0}}, load_word};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= '0;
      held    <= '0;
    end else begin
      // new bytes land just above the ones still held after this shift
      shift_q <= (out_write ? (shift_q >> {out_bytes, 3'b000}) : shift_q) |
                 (o_read ? (load_wide << {4'(SHIFT_BYTES) - free_bytes, 3'b000}) : '0);
      held    <= held + (o_read ? in_bytes : 4'd0) - (out_write ? out_bytes : 4'd0);
    end
  end

  assign o_phy_data  = shift_q[WORD_W-1:0];   // lane k takes byte k
  assign o_phy_write = out_write ? ({MAX_LANES{1'b1}} >> (MAX_LANES - out_bytes)) : '0;

endmodule

// ==== verilog/dsi_word_fifo.sv ====
module dsi_word_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_write,
  input  dsi_proto_pkg::fifo_entry_t i_entry,
  input  logic                       i_read,
  output dsi_proto_pkg::fifo_entry_t o_head,
  output logic                       o_empty,
  output logic                       o_full
);
  import dsi_proto_pkg::*;

  fifo_entry_t           mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  do_write;
  logic                  do_read;

  assign do_write = i_write & !o_full;
  assign do_read  = i_read & !o_empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= i_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + do_write;   // pointers wrap on their own
      rd_ptr <= rd_ptr + do_read;
      count  <= count + do_write - do_read;
    end
  end

  assign o_head  = mem[rd_ptr];      // show-ahead
  assign o_empty = (count == '0);
  assign o_full  = (count == FIFO_DEPTH);

endmodule

// ==== verilog/dsi_frame_sequencer.sv ====
module dsi_frame_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_enable,
  input  logic                       i_line_start,
  input  logic                       i_line_end,
  input  logic                       i_last_vbp,
  input  logic                       i_last_act,
  input  logic                       i_last_vfp,
  input  dsi_video_pkg::hbp_t        i_lines_hbp,
  input  dsi_video_pkg::hact_t       i_lines_hact,
  input  dsi_proto_pkg::word_t       i_pix_data,
  input  logic                       i_pix_valid,
  input  logic                       i_pix_line_ready,
  input  logic                       i_fifo_full,
  output logic                       o_pix_read,
  output logic                       o_fifo_write,
  output dsi_proto_pkg::fifo_entry_t o_fifo_entry,
  output logic                       o_pix_underflow
);
  import dsi_proto_pkg::*;
  import dsi_video_pkg::*;

  seq_state_t  state;
  seq_state_t  state_next;
  logic        sync_state;
  logic        long_hdr_state;
  logic        crc_state;
  logic        hdr_pending;
  logic        crc_ready;
  logic        hdr_write;
  logic        long_hdr_write;
  logic        payload_write;
  logic        crc_write;
  data_id_t    data_id;
  word_count_t word_count;
  word_count_t blank_bytes;
  word_count_t pix_bytes;
  hact_t       pix_words;
  hact_t       words_left;
  ecc_t        ecc;
  word_t       payload;
  crc_t        crc;

  assign sync_state     = state inside {SEND_VSS, SEND_HSS_VBP, SEND_HSS_ACT, SEND_HSS_VFP};
  assign long_hdr_state = state inside {SEND_BLANK_HEADER, SEND_DATA_HEADER};
  assign crc_state      = state inside {SEND_BLANK_CRC, SEND_DATA_CRC};

  // a sync header missed at line start goes out as soon as there is room
  assign hdr_write      = sync_state & (i_line_start | hdr_pending) & !i_fifo_full;
  assign long_hdr_write = long_hdr_state & !i_fifo_full;
  assign payload_write  = !i_fifo_full & ((state == SEND_BLANK) |
                                          ((state == SEND_DATA) & i_pix_valid));
  assign crc_write      = crc_state & crc_ready & !i_fifo_full;
  assign o_fifo_write   = hdr_write | long_hdr_write | payload_write | crc_write;

  assign blank_bytes = {8'b0, i_lines_hbp, 2'b00};
  assign pix_bytes   = word_count_t'(i_lines_hact) * 16'd3;
  assign pix_words   = hact_t'(pix_bytes >> 2);

  always_comb begin
    state_next = state;
    case (state)
      IDLE:              if (i_line_end & i_enable & i_pix_line_ready) state_next = SEND_VSS;
      SEND_VSS:          if (i_line_end) state_next = SEND_HSS_VBP;
      SEND_HSS_VBP:      if (i_line_end & i_last_vbp) state_next = SEND_HSS_ACT;
      SEND_HSS_ACT:      if (hdr_write) state_next = SEND_BLANK_HEADER;
      SEND_BLANK_HEADER: if (long_hdr_write) state_next = SEND_BLANK;
      SEND_BLANK:        if (payload_write & (words_left == hact_t'(1))) state_next = SEND_BLANK_CRC;
      SEND_BLANK_CRC:    if (crc_write) state_next = SEND_DATA_HEADER;
      SEND_DATA_HEADER:  if (long_hdr_write) state_next = SEND_DATA;
      SEND_DATA:         if (payload_write & (words_left == hact_t'(1))) state_next = SEND_DATA_CRC;
      SEND_DATA_CRC:     if (crc_write) state_next = SEND_HFP;
      SEND_HFP:          if (i_line_end) state_next = i_last_act ? SEND_HSS_VFP : SEND_HSS_ACT;
      SEND_HSS_VFP:      if (i_line_end & i_last_vfp) state_next = i_enable ? SEND_VSS : IDLE;
      default:           state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= IDLE;
      hdr_pending <= 1'b0;
      crc_ready   <= 1'b0;
      words_left  <= '0;
    end else begin
      state       <= state_next;
      hdr_pending <= sync_state & (hdr_pending | i_line_start) & !hdr_write;
      crc_ready   <= crc_state & !crc_write;   // one idle cycle before the trailer
      if (long_hdr_write) begin
        words_left <= (state == SEND_DATA_HEADER) ? pix_words : hact_t'(i_lines_hbp);
      end else if (payload_write) begin
        words_left <= words_left - 1'b1;
      end
    end
  end

  always_comb begin
    case (state)
      SEND_VSS:          data_id = ID_VSS;
      SEND_BLANK_HEADER: data_id = ID_BLANKING;
      SEND_DATA_HEADER:  data_id = ID_PPS24;
      default:           data_id = ID_HSS;
    endcase
  end

  always_comb begin
    case (state)
      SEND_BLANK_HEADER: word_count = blank_bytes;
      SEND_DATA_HEADER:  word_count = pix_bytes;
      default:           word_count = '0;
    endcase
  end

  dsi_ecc_gen dsi_ecc_gen_inst (
    .i_header ( 24'({word_count, data_id})),
    .o_ecc    (ecc)
  );

  assign payload = (state == SEND_DATA) ? i_pix_data : '0;   // blanking is zeros

  dsi_crc16 dsi_crc16_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_clear (long_hdr_state),
    .i_write (payload_write),
    .i_data  (payload),
    .o_crc   (crc)
  );

  always_comb begin
    if (crc_state) begin
      o_fifo_entry = {1'b1, 16'b0, crc};      // half entry, low two bytes only
    end else if ((state == SEND_BLANK) || (state == SEND_DATA)) begin
      o_fifo_entry = {1'b0, payload};
    end else begin
      o_fifo_entry = {1'b0, ecc, word_count, data_id};
    end
  end

  assign o_pix_read      = payload_write & (state == SEND_DATA);
  assign o_pix_underflow = (state == SEND_DATA_HEADER) & !i_pix_line_ready;

endmodule

// ==== verilog/dsi_crc16.sv ====
module dsi_crc16 (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_clear,
  input  logic                 i_write,
  input  dsi_proto_pkg::word_t i_data,
  output dsi_proto_pkg::crc_t  o_crc
);
  import dsi_proto_pkg::*;

  // bits go in lsb first, which also keeps the byte order
  function automatic crc_t crc_fold(crc_t crc_in, word_t data);
    crc_t crc;
    crc = crc_in;
    for (int i = 0; i < WORD_W; i++) begin
      if (crc[0] ^ data[i]) begin
        crc = (crc >> 1) ^ CRC_POLY;
      end else begin
        crc = crc >> 1;
      end
    end
    return crc;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      o_crc <= CRC_SEED;
    end else if (i_write) begin
      o_crc <= crc_fold(o_crc, i_data);
    end
  end

endmodule

// ==== verilog/dsi_ecc_gen.sv ====
module dsi_ecc_gen (
  input  logic [23:0]         i_header,
  output dsi_proto_pkg::ecc_t o_ecc
);
  import dsi_proto_pkg::*;

  logic [5:0] parity;

  // hamming parity, one masked xor reduction per bit
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      parity[i] = ^(i_header & ECC_MASKS[i]);
    end
  end

  assign o_ecc = {2'b00, parity};

endmodule

// ==== verilog/dsi_video_timer.sv ====
module dsi_video_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_enable,
  input  dsi_video_pkg::hpix_t   i_lines_htotal,
  input  dsi_video_pkg::vlines_t i_lines_vtotal,
  input  dsi_video_pkg::vlines_t i_lines_vsync,
  input  dsi_video_pkg::vlines_t i_lines_vbp,
  input  dsi_video_pkg::vlines_t i_lines_vact,
  output logic                   o_line_start,
  output logic                   o_line_end,
  output logic                   o_last_vbp,
  output logic                   o_last_act,
  output logic                   o_last_vfp
);
  import dsi_video_pkg::*;

  hpix_t   pix_cnt;
  vlines_t line_cnt;
  vlines_t vbp_line;
  vlines_t act_line;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_cnt <= '0;
    end else if (i_enable) begin
      if (pix_cnt == '0) begin
        pix_cnt <= i_lines_htotal - 1'b1;
      end else begin
        pix_cnt <= pix_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_cnt <= '0;
    end else if (o_line_end) begin
      if (line_cnt == '0) begin
        line_cnt <= i_lines_vtotal - 1'b1;   // wraps into the vss line
      end else begin
        line_cnt <= line_cnt - 1'b1;
      end
    end
  end

  // line numbers of the last back porch and last active line
  always_ff @(posedge clk) begin
    vbp_line <= i_lines_vtotal - (i_lines_vsync + i_lines_vbp);
    act_line <= i_lines_vtotal - (i_lines_vsync + i_lines_vbp + i_lines_vact);
  end

  assign o_line_start = i_enable & (pix_cnt == '0);
  assign o_line_end   = i_enable & (pix_cnt == hpix_t'(1));
  assign o_last_vbp   = (line_cnt == vbp_line);
  assign o_last_act   = (line_cnt == act_line);
  assign o_last_vfp   = (line_cnt == '0);

endmodule

// ==== verilog/dsi_video_pkg.sv ====
package dsi_video_pkg;

  typedef logic [11:0] vlines_t;
  typedef logic [10:0] hpix_t;   // pixel clocks per line
  typedef logic [9:0]  hact_t;
  typedef logic [5:0]  hbp_t;    // blanking payload in words

  typedef enum logic [3:0] {
    IDLE,
    SEND_VSS,
    SEND_HSS_VBP,
    SEND_HSS_ACT,
    SEND_BLANK_HEADER,
    SEND_BLANK,
    SEND_BLANK_CRC,
    SEND_DATA_HEADER,
    SEND_DATA,
    SEND_DATA_CRC,
    SEND_HFP,
    SEND_HSS_VFP
  } seq_state_t;

endpackage

// ==== verilog/dsi_proto_pkg.sv ====
package dsi_proto_pkg;

  localparam int WORD_W       = 32;
  localparam int FIFO_ENTRY_W = WORD_W + 1;    // half flag on top of a word
  localparam int FIFO_DEPTH   = 4;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  localparam int MAX_LANES    = 4;
  localparam int SHIFT_BYTES  = 8;

  typedef logic [WORD_W-1:0]       word_t;     // lsb byte goes out first
  typedef logic [7:0]              data_id_t;
  typedef logic [15:0]             word_count_t;
  typedef logic [7:0]              ecc_t;
  typedef logic [15:0]             crc_t;
  typedef logic [FIFO_ENTRY_W-1:0] fifo_entry_t;
  typedef logic [2:0]              lane_count_t;

  localparam data_id_t ID_VSS      = 8'h01;
  localparam data_id_t ID_HSS      = 8'h21;
  localparam data_id_t ID_BLANKING = 8'h19;
  localparam data_id_t ID_PPS24    = 8'h3E;

  localparam crc_t CRC_SEED = 16'hFFFF;
  localparam crc_t CRC_POLY = 16'h8408;       // x16+x12+x5+1, reflected

  // header bits covered by each parity bit, p5 down to p0
  localparam logic [5:0][23:0] ECC_MASKS = {24'hEFFC00, 24'hDF03F0, 24'hB8E38E,
                                            24'h749A6D, 24'hF2555B, 24'hF12CB7};

endpackage
